//--- wbuf_top.f
hw/wbuf_pkg.sv
hw/mem_pkg.sv
hw/mem_bus_if.sv
hw/wbuf_id_gen.sv
hw/wbuf_store.sv
hw/wbuf_drain.sv
hw/load_port.sv
hw/mem_arbiter.sv
hw/wbuf_mem.sv
hw/wbuf_top.sv
tb/wbuf_tb_clk.sv
tb/wbuf_tb.sv

//--- Bender.yml
package:
  name: wbuf

sources:
  - hw/wbuf_pkg.sv
  - hw/mem_pkg.sv
  - hw/mem_bus_if.sv
  - hw/wbuf_id_gen.sv
  - hw/wbuf_store.sv
  - hw/wbuf_drain.sv
  - hw/load_port.sv
  - hw/mem_arbiter.sv
  - hw/wbuf_mem.sv
  - hw/wbuf_top.sv
  - target: simulation
    files:
      - tb/wbuf_tb_clk.sv
      - tb/wbuf_tb.sv

//--- tb/wbuf_tb.sv
`timescale 1ns/1ps

module wbuf_tb;

    localparam int WBUF_SIZE      = wbuf_pkg::WBUF_SIZE_DEF;
    localparam int ADDR_W         = wbuf_pkg::ADDR_W_DEF;
    localparam int DATA_W         = wbuf_pkg::DATA_W_DEF;
    localparam int HALF_WORDS     = 2 ** (ADDR_W - 1);
    localparam int MIX_STORES     = 64;
    localparam int MIX_LOADS      = 48;
    // About 1000 cycles of traffic, with a wide margin for arbitration stalls.
    localparam int TIMEOUT_CYCLES = 20000;

    logic              clk;
    logic              rst_n;
    logic              store_valid;
    logic              store_ready;
    logic [ADDR_W-1:0] store_addr;
    logic [DATA_W-1:0] store_data;
    logic              drain_hold;
    logic              wbuf_empty;
    logic              load_valid;
    logic              load_ready;
    logic [ADDR_W-1:0] load_addr;
    logic              load_rvalid;
    logic [DATA_W-1:0] load_rdata;

    logic [DATA_W-1:0] model [logic [ADDR_W-1:0]];   // Memory after all drains.
    logic [DATA_W-1:0] exp_q [$];
    logic [ADDR_W-1:0] exp_addr_q [$];
    logic [DATA_W-1:0] exp_word;
    logic [ADDR_W-1:0] exp_addr;
    logic [ADDR_W-1:0] base_addr;
    logic [ADDR_W-1:0] mix_st_addr [MIX_STORES];
    logic [DATA_W-1:0] mix_st_data [MIX_STORES];
    logic [ADDR_W-1:0] mix_ld_addr [MIX_LOADS];
    int                mix_st_gap  [MIX_STORES];
    int                mix_ld_gap  [MIX_LOADS];
    logic [31:0]       rng_state = 32'hd277_6363;
    int                cycle_cnt = 0;
    int                data_errors = 0;
    int                ctrl_errors = 0;
    int                loads_issued = 0;
    int                loads_checked = 0;

    wbuf_tb_clk u_clk (.clk(clk), .rst_n(rst_n));

    wbuf_top #(.WBUF_SIZE(WBUF_SIZE), .ADDR_W(ADDR_W), .DATA_W(DATA_W)) UUT
    (
        .clk         (clk),
        .rst_n       (rst_n),
        .store_valid (store_valid),
        .store_ready (store_ready),
        .store_addr  (store_addr),
        .store_data  (store_data),
        .drain_hold  (drain_hold),
        .wbuf_empty  (wbuf_empty),
        .load_valid  (load_valid),
        .load_ready  (load_ready),
        .load_addr   (load_addr),
        .load_rvalid (load_rvalid),
        .load_rdata  (load_rdata)
    );

    // LCG whose top bits are the better ones.
    function automatic logic [31:0] rand_bits(input int n);
        rng_state = rng_state * 32'd1664525 + 32'd1013904223;
        return rng_state >> (32 - n);
    endfunction

    function automatic logic [DATA_W-1:0] expected_word(input logic [ADDR_W-1:0] addr);
        if (model.exists(addr))
            return model[addr];
        return 'x;
    endfunction

    // Called on a falling edge; returns on the falling edge after acceptance.
    task automatic issue_store(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] data);
        store_valid = 1'b1;
        store_addr  = addr;
        store_data  = data;
        while (!store_ready)
            @(negedge clk);
        model[addr] = data;   // Taken at the coming edge.
        @(negedge clk);
        store_valid = 1'b0;
    endtask

    task automatic issue_load(input logic [ADDR_W-1:0] addr);
        while (!load_ready)
            @(negedge clk);
        load_valid = 1'b1;
        load_addr  = addr;
        @(negedge clk);
        load_valid = 1'b0;
        exp_q.push_back(expected_word(addr));
        exp_addr_q.push_back(addr);
        loads_issued++;
    endtask

    task automatic wait_empty();
        while (!wbuf_empty)
            @(negedge clk);
    endtask

    task automatic wait_loads();
        while (exp_q.size() != 0)
            @(negedge clk);
    endtask

    // Response checker.
    always @(negedge clk)
    begin
        if (rst_n)
        begin
            if (exp_q.size() != 0)
                assert (!load_ready)
                else
                begin
                    ctrl_errors++;
                    $display("FAIL %0t: load_ready high with a load outstanding", $time);
                end
            if (load_rvalid)
            begin
                assert (exp_q.size() != 0)
                else
                begin
                    ctrl_errors++;
                    $display("Load response at %0t arrived with no load outstanding.", $time);
                end
                if (exp_q.size() != 0)
                begin
                    exp_word = exp_q.pop_front();
                    exp_addr = exp_addr_q.pop_front();
                    loads_checked++;
                    assert (load_rdata === exp_word)
                    else
                    begin
                        data_errors++;
                        $display("FAIL %0t: load addr %h returned %h, expected %h",
                                 $time, exp_addr, load_rdata, exp_word);
                    end
                end
            end
        end
    end

    always @(posedge clk)
    begin
        cycle_cnt++;
        if (cycle_cnt >= TIMEOUT_CYCLES)
        begin
            $display("Run did not finish within %0d cycles; %0d of %0d loads answered.",
                     TIMEOUT_CYCLES, loads_checked, loads_issued);
            $display("TESTS FAILED");
            $finish;
        end
    end

    initial
    begin
        store_valid = 1'b0;
        store_addr  = '0;
        store_data  = '0;
        drain_hold  = 1'b0;
        load_valid  = 1'b0;
        load_addr   = '0;
        @(posedge rst_n);
        @(negedge clk);

        assert (store_ready && load_ready && wbuf_empty && !load_rvalid)
        else
        begin
            ctrl_errors++;
            $display("FAIL %0t: idle outputs wrong after reset", $time);
        end

        // Fill the buffer with drains held, repeating addresses.
        drain_hold = 1'b1;
        base_addr  = ADDR_W'(rand_bits(ADDR_W));
        for (int i = 0; i < WBUF_SIZE; i++)
        begin
            assert (store_ready)
            else
            begin
                ctrl_errors++;
                $display("FAIL %0t: store_ready low with %0d slots taken", $time, i);
            end
            issue_store(base_addr + ADDR_W'(i % 3), rand_bits(DATA_W));
        end
        store_valid = 1'b1;
        store_addr  = base_addr + ADDR_W'(1);
        store_data  = rand_bits(DATA_W);
        repeat (8)
        begin
            assert (!store_ready && !wbuf_empty)
            else
            begin
                ctrl_errors++;
                $display("FAIL %0t: full buffer still accepts stores", $time);
            end
            @(negedge clk);
        end
        drain_hold = 1'b0;
        issue_store(store_addr, store_data);

        wait_empty();
        foreach (model[a])
            issue_load(a);
        wait_loads();

        // Upper half preload.
        for (int a = HALF_WORDS; a < 2 * HALF_WORDS; a++)
            issue_store(ADDR_W'(a), rand_bits(DATA_W));
        wait_empty();

        for (int i = 0; i < MIX_STORES; i++)
        begin
            mix_st_addr[i] = ADDR_W'(rand_bits(ADDR_W - 1));
            mix_st_data[i] = rand_bits(DATA_W);
            mix_st_gap[i]  = int'(rand_bits(2));
        end
        for (int i = 0; i < MIX_LOADS; i++)
        begin
            mix_ld_addr[i] = ADDR_W'(HALF_WORDS) | ADDR_W'(rand_bits(ADDR_W - 1));
            mix_ld_gap[i]  = int'(rand_bits(2));
        end

        fork
            begin
                for (int i = 0; i < MIX_STORES; i++)
                begin
                    repeat (mix_st_gap[i]) @(negedge clk);
                    issue_store(mix_st_addr[i], mix_st_data[i]);
                end
            end
            begin
                for (int i = 0; i < MIX_LOADS; i++)
                begin
                    repeat (mix_ld_gap[i]) @(negedge clk);
                    issue_load(mix_ld_addr[i]);
                end
            end
        join
        wait_loads();
        wait_empty();

        // Lower half sweep.
        for (int a = 0; a < HALF_WORDS; a++)
        begin
            if (model.exists(ADDR_W'(a)))
                issue_load(ADDR_W'(a));
        end
        wait_loads();
        repeat (2) @(negedge clk);

        $display("Loads checked: %0d, data errors: %0d, control errors: %0d",
                 loads_checked, data_errors, ctrl_errors);
        if (data_errors + ctrl_errors == 0)
            $display("TESTS PASSED");
        else
            $display("TESTS FAILED");
        $finish;
    end

endmodule

//--- tb/wbuf_tb_clk.sv
`timescale 1ns/1ps

module wbuf_tb_clk
(
    output logic clk,
    output logic rst_n
);

    initial
    begin
        clk = 1'b0;
        forever #2 clk = ~clk;   // 4 ns period.
    end

    initial
    begin
        rst_n = 1'b0;
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
    end

endmodule

//--- hw/wbuf_top.sv
`timescale 1ns/1ps

module wbuf_top
#(
    parameter int WBUF_SIZE = wbuf_pkg::WBUF_SIZE_DEF,
    parameter int ADDR_W    = wbuf_pkg::ADDR_W_DEF,
    parameter int DATA_W    = wbuf_pkg::DATA_W_DEF
)
(
    input  logic              clk,
    input  logic              rst_n,
    input  logic              store_valid,
    output logic              store_ready,
    input  logic [ADDR_W-1:0] store_addr,
    input  logic [DATA_W-1:0] store_data,
    input  logic              drain_hold,
    output logic              wbuf_empty,
    input  logic              load_valid,
    output logic              load_ready,
    input  logic [ADDR_W-1:0] load_addr,
    output logic              load_rvalid,
    output logic [DATA_W-1:0] load_rdata
);

    logic              head_valid;
    logic [ADDR_W-1:0] head_addr;
    logic [DATA_W-1:0] head_data;
    logic              head_pop;
    logic              free_valid;

    logic              mem_we;
    logic              mem_en;
    logic [ADDR_W-1:0] mem_addr;
    logic [DATA_W-1:0] mem_wdata;
    logic [DATA_W-1:0] mem_rdata;

    mem_bus_if #(.ADDR_W(ADDR_W), .DATA_W(DATA_W)) drain_bus ();
    mem_bus_if #(.ADDR_W(ADDR_W), .DATA_W(DATA_W)) load_bus ();

    wbuf_store #(.WBUF_SIZE(WBUF_SIZE), .ADDR_W(ADDR_W), .DATA_W(DATA_W)) u_store
    (
        .clk         (clk),
        .rst_n       (rst_n),
        .store_valid (store_valid),
        .store_ready (store_ready),
        .store_addr  (store_addr),
        .store_data  (store_data),
        .head_valid  (head_valid),
        .head_addr   (head_addr),
        .head_data   (head_data),
        .head_pop    (head_pop),
        .free_valid  (free_valid),
        .wbuf_empty  (wbuf_empty)
    );

    wbuf_drain #(.ADDR_W(ADDR_W), .DATA_W(DATA_W)) u_drain
    (
        .clk        (clk),
        .rst_n      (rst_n),
        .drain_hold (drain_hold),
        .head_valid (head_valid),
        .head_addr  (head_addr),
        .head_data  (head_data),
        .head_pop   (head_pop),
        .free_valid (free_valid),
        .bus        (drain_bus)
    );

    load_port #(.ADDR_W(ADDR_W), .DATA_W(DATA_W)) u_load
    (
        .clk         (clk),
        .rst_n       (rst_n),
        .load_valid  (load_valid),
        .load_ready  (load_ready),
        .load_addr   (load_addr),
        .load_rvalid (load_rvalid),
        .load_rdata  (load_rdata),
        .bus         (load_bus)
    );

    mem_arbiter #(.ADDR_W(ADDR_W), .DATA_W(DATA_W)) u_arbiter
    (
        .clk       (clk),
        .rst_n     (rst_n),
        .drain_bus (drain_bus),
        .load_bus  (load_bus),
        .mem_we    (mem_we),
        .mem_en    (mem_en),
        .mem_addr  (mem_addr),
        .mem_wdata (mem_wdata),
        .mem_rdata (mem_rdata)
    );

    wbuf_mem #(.ADDR_W(ADDR_W), .DATA_W(DATA_W)) u_mem
    (
        .clk       (clk),
        .mem_en    (mem_en),
        .mem_we    (mem_we),
        .mem_addr  (mem_addr),
        .mem_wdata (mem_wdata),
        .mem_rdata (mem_rdata)
    );

endmodule

//--- hw/wbuf_mem.sv
`timescale 1ns/1ps

module wbuf_mem
#(
    parameter int ADDR_W = wbuf_pkg::ADDR_W_DEF,
    parameter int DATA_W = wbuf_pkg::DATA_W_DEF
)
(
    input  logic              clk,
    input  logic              mem_en,
    input  logic              mem_we,
    input  logic [ADDR_W-1:0] mem_addr,
    input  logic [DATA_W-1:0] mem_wdata,
    output logic [DATA_W-1:0] mem_rdata
);

    logic [DATA_W-1:0] mem [2**ADDR_W];

    always_ff @(posedge clk)
    begin
        if (mem_en)
        begin
            if (mem_we)
                mem[mem_addr] <= mem_wdata;
            else
                mem_rdata <= mem[mem_addr];  // Registered read.
        end
    end

endmodule

//--- hw/mem_arbiter.sv
`timescale 1ns/1ps

module mem_arbiter
#(
    parameter int ADDR_W = wbuf_pkg::ADDR_W_DEF,
    parameter int DATA_W = wbuf_pkg::DATA_W_DEF
)
(
    input  logic              clk,
    input  logic              rst_n,
    mem_bus_if.arbiter        drain_bus,
    mem_bus_if.arbiter        load_bus,
    output logic              mem_we,
    output logic              mem_en,
    output logic [ADDR_W-1:0] mem_addr,
    output logic [DATA_W-1:0] mem_wdata,
    input  logic [DATA_W-1:0] mem_rdata
);

    mem_pkg::mem_master_e last_q;
    logic                 sel_load;

    // On a tie the side not served last goes first.
    assign drain_bus.gnt = drain_bus.req &&
                           (!load_bus.req || last_q == mem_pkg::MST_LOAD);
    assign load_bus.gnt  = load_bus.req &&
                           (!drain_bus.req || last_q == mem_pkg::MST_DRAIN);

    always_ff @(posedge clk)
    begin
        if (!rst_n)
            last_q <= mem_pkg::MST_LOAD;
        else if (load_bus.gnt)
            last_q <= mem_pkg::MST_LOAD;
        else if (drain_bus.gnt)
            last_q <= mem_pkg::MST_DRAIN;
    end

    assign sel_load  = load_bus.gnt;
    assign mem_en    = drain_bus.gnt || load_bus.gnt;
    assign mem_we    = mem_en &&
                       ((sel_load ? load_bus.op : drain_bus.op) == mem_pkg::MEM_WRITE);
    assign mem_addr  = sel_load ? load_bus.addr  : drain_bus.addr;
    assign mem_wdata = sel_load ? load_bus.wdata : drain_bus.wdata;

    assign drain_bus.rdata = mem_rdata;
    assign load_bus.rdata  = mem_rdata;

    a_one_grant : assert property (@(posedge clk) disable iff (!rst_n)
        !(drain_bus.gnt && load_bus.gnt));

endmodule

//--- hw/load_port.sv
`timescale 1ns/1ps

module load_port
#(
    parameter int ADDR_W = wbuf_pkg::ADDR_W_DEF,
    parameter int DATA_W = wbuf_pkg::DATA_W_DEF
)
(
    input  logic              clk,
    input  logic              rst_n,
    input  logic              load_valid,
    output logic              load_ready,
    input  logic [ADDR_W-1:0] load_addr,
    output logic              load_rvalid,
    output logic [DATA_W-1:0] load_rdata,
    mem_bus_if.requester      bus
);

    logic              req_q;
    logic              rvalid_q;
    logic [ADDR_W-1:0] addr_q;

    always_ff @(posedge clk)
    begin
        if (load_valid && load_ready)
            addr_q <= load_addr;
    end

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            req_q    <= 1'b0;
            rvalid_q <= 1'b0;
        end
        else
        begin
            if (load_valid && load_ready)
                req_q <= 1'b1;
            else if (bus.gnt)
                req_q <= 1'b0;
            rvalid_q <= req_q && bus.gnt;   // Memory data lands a cycle later.
        end
    end

    assign load_ready  = !req_q && !rvalid_q;
    assign load_rvalid = rvalid_q;
    assign load_rdata  = bus.rdata;

    assign bus.req   = req_q;
    assign bus.op    = mem_pkg::MEM_READ;
    assign bus.addr  = addr_q;
    assign bus.wdata = '0;

endmodule

//--- hw/wbuf_drain.sv
`timescale 1ns/1ps

module wbuf_drain
#(
    parameter int ADDR_W = wbuf_pkg::ADDR_W_DEF,
    parameter int DATA_W = wbuf_pkg::DATA_W_DEF
)
(
    input  logic              clk,
    input  logic              rst_n,
    input  logic              drain_hold,
    input  logic              head_valid,
    input  logic [ADDR_W-1:0] head_addr,
    input  logic [DATA_W-1:0] head_data,
    output logic              head_pop,
    output logic              free_valid,
    mem_bus_if.requester      bus
);

    wbuf_pkg::drain_state_e state;
    logic                   done;

    assign done = (state == wbuf_pkg::DRAIN_REQ) && bus.gnt;

    always_ff @(posedge clk)
    begin
        if (!rst_n)
            state <= wbuf_pkg::DRAIN_IDLE;
        else
        begin
            case (state)
                wbuf_pkg::DRAIN_IDLE:
                begin
                    if (head_valid && !drain_hold)
                        state <= wbuf_pkg::DRAIN_REQ;
                end
                wbuf_pkg::DRAIN_REQ:
                begin
                    if (bus.gnt)
                        state <= wbuf_pkg::DRAIN_IDLE;
                end
                default: state <= wbuf_pkg::DRAIN_IDLE;
            endcase
        end
    end

    // Head entry stays put while requesting.
    assign bus.req   = (state == wbuf_pkg::DRAIN_REQ);
    assign bus.op    = mem_pkg::MEM_WRITE;
    assign bus.addr  = head_addr;
    assign bus.wdata = head_data;

    assign head_pop   = done;
    assign free_valid = done;

    a_req_held : assert property (@(posedge clk) disable iff (!rst_n)
        bus.req && !bus.gnt |=> bus.req && $stable(bus.addr) && $stable(bus.wdata));

endmodule

//--- hw/wbuf_store.sv
`timescale 1ns/1ps

module wbuf_store
#(
    parameter int WBUF_SIZE = wbuf_pkg::WBUF_SIZE_DEF,
    parameter int ADDR_W    = wbuf_pkg::ADDR_W_DEF,
    parameter int DATA_W    = wbuf_pkg::DATA_W_DEF
)
(
    input  logic              clk,
    input  logic              rst_n,
    input  logic              store_valid,
    output logic              store_ready,
    input  logic [ADDR_W-1:0] store_addr,
    input  logic [DATA_W-1:0] store_data,
    output logic              head_valid,
    output logic [ADDR_W-1:0] head_addr,
    output logic [DATA_W-1:0] head_data,
    input  logic              head_pop,
    input  logic              free_valid,
    output logic              wbuf_empty
);

    localparam int ID_W  = (WBUF_SIZE > 1) ? $clog2(WBUF_SIZE) : 1;
    localparam int CNT_W = $clog2(WBUF_SIZE + 1);

    logic [ADDR_W-1:0] slot_addr [WBUF_SIZE];
    logic [DATA_W-1:0] slot_data [WBUF_SIZE];
    logic [ID_W-1:0]   order_q   [WBUF_SIZE];  // Ids in arrival order.

    logic [ID_W-1:0]   wr_ptr;
    logic [ID_W-1:0]   rd_ptr;
    logic [CNT_W-1:0]  q_count;
    logic [ID_W-1:0]   alloc_id;
    logic [ID_W-1:0]   head_id;
    logic              store_push;

    wbuf_id_gen #(.WBUF_SIZE(WBUF_SIZE)) u_id_gen
    (
        .clk         (clk),
        .rst_n       (rst_n),
        .alloc_valid (store_valid),
        .alloc_ready (store_ready),
        .alloc_id    (alloc_id),
        .free_valid  (free_valid),
        .free_id     (head_id),   // Drains are in order.
        .empty       (wbuf_empty)
    );

    assign store_push = store_valid && store_ready;

    always_ff @(posedge clk)
    begin
        if (store_push)
        begin
            slot_addr[alloc_id] <= store_addr;
            slot_data[alloc_id] <= store_data;
            order_q[wr_ptr]     <= alloc_id;
        end
    end

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            wr_ptr  <= '0;
            rd_ptr  <= '0;
            q_count <= '0;
        end
        else
        begin
            if (store_push)
                wr_ptr <= (wr_ptr == ID_W'(WBUF_SIZE - 1)) ? '0 : wr_ptr + 1'b1;
            if (head_pop)
                rd_ptr <= (rd_ptr == ID_W'(WBUF_SIZE - 1)) ? '0 : rd_ptr + 1'b1;
            case ({store_push, head_pop})
                2'b10:   q_count <= q_count + 1'b1;
                2'b01:   q_count <= q_count - 1'b1;
                default: q_count <= q_count;
            endcase
        end
    end

    assign head_id    = order_q[rd_ptr];
    assign head_valid = (q_count != '0);
    assign head_addr  = slot_addr[head_id];
    assign head_data  = slot_data[head_id];

    a_pop_nonempty : assert property (@(posedge clk) disable iff (!rst_n)
        head_pop |-> head_valid);

endmodule

//--- hw/wbuf_id_gen.sv
`timescale 1ns/1ps

module wbuf_id_gen_entry
(
    input  logic clk,
    input  logic rst_n,
    output logic ready,
    input  logic alloc,
    input  logic free
);

    logic entry_vld;

    always_ff @(posedge clk)
    begin
        if (!rst_n)
            entry_vld <= 1'b0;
        else if (alloc | free)
            entry_vld <= alloc;
    end

    assign ready = !entry_vld;

endmodule

module wbuf_id_gen
#(
    parameter int WBUF_SIZE = wbuf_pkg::WBUF_SIZE_DEF
)
(
    input  logic                                           clk,
    input  logic                                           rst_n,
    input  logic                                           alloc_valid,
    output logic                                           alloc_ready,
    output logic [((WBUF_SIZE > 1) ? $clog2(WBUF_SIZE) : 1)-1:0] alloc_id,
    input  logic                                           free_valid,
    input  logic [((WBUF_SIZE > 1) ? $clog2(WBUF_SIZE) : 1)-1:0] free_id,
    output logic                                           empty
);

    localparam int ID_W = (WBUF_SIZE > 1) ? $clog2(WBUF_SIZE) : 1;

    logic [WBUF_SIZE-1:0] wbuf_ready;
    logic [WBUF_SIZE-1:0] wbuf_alloc;
    logic [WBUF_SIZE-1:0] wbuf_free;

    // Lowest free slot wins.
    always_comb
    begin
        alloc_id = '0;
        for (int i = WBUF_SIZE - 1; i >= 0; i--)
        begin
            if (wbuf_ready[i])
                alloc_id = ID_W'(i);
        end
    end

    for (genvar i = 0; i < WBUF_SIZE; i++)
    begin : g_entry
        assign wbuf_alloc[i] = alloc_valid && alloc_ready && (alloc_id == ID_W'(i));
        assign wbuf_free[i]  = free_valid && (free_id == ID_W'(i));

        wbuf_id_gen_entry u_entry
        (
            .clk   (clk),
            .rst_n (rst_n),
            .ready (wbuf_ready[i]),
            .alloc (wbuf_alloc[i]),
            .free  (wbuf_free[i])
        );
    end

    assign alloc_ready = |wbuf_ready;
    assign empty       = &wbuf_ready;

    // A release must name a slot that the store side took earlier.
    a_free_busy_id : assert property (@(posedge clk) disable iff (!rst_n)
        free_valid |-> !wbuf_ready[free_id]);

endmodule

//--- hw/mem_bus_if.sv
`timescale 1ns/1ps

interface mem_bus_if
#(
    parameter int ADDR_W = wbuf_pkg::ADDR_W_DEF,
    parameter int DATA_W = wbuf_pkg::DATA_W_DEF
);

    logic                  req;
    mem_pkg::mem_op_e      op;
    logic [ADDR_W-1:0]     addr;
    logic [DATA_W-1:0]     wdata;
    logic                  gnt;   // Transfer at the edge with req.
    logic [DATA_W-1:0]     rdata; // Valid one cycle after a read grant.

    modport requester
    (
        output req, op, addr, wdata,
        input  gnt, rdata
    );

    modport arbiter
    (
        input  req, op, addr, wdata,
        output gnt, rdata
    );

endinterface

//--- hw/mem_pkg.sv
package mem_pkg;

    typedef enum logic
    {
        MEM_READ  = 1'b0,
        MEM_WRITE = 1'b1
    } mem_op_e;

    // Requesters on the shared memory bus.
    typedef enum logic
    {
        MST_DRAIN = 1'b0,
        MST_LOAD  = 1'b1
    } mem_master_e;

endpackage

//--- hw/wbuf_pkg.sv
package wbuf_pkg;

    // Default geometry that the top level overrides.
    localparam int WBUF_SIZE_DEF = 4;
    localparam int ADDR_W_DEF    = 8;   // Word address.
    localparam int DATA_W_DEF    = 32;

    // Drain engine.
    typedef enum logic
    {
        DRAIN_IDLE = 1'b0,
        DRAIN_REQ  = 1'b1
    } drain_state_e;

endpackage
